// File: source/clkctl_pkg.sv
//####################
// clock control package
// widths, register map and the structs shared by
// the register block and the divider channels
//####################
package clkctl_pkg;

   //####################
   // widths
   //####################
   typedef logic [7:0]  div_count_t;   // counter, period, edge position
   typedef logic [7:0]  wb_addr_t;     // word address
   typedef logic [31:0] wb_data_t;

   // word offsets inside one channel window (4 words per channel)
   localparam logic [1:0] REG_CTRL   = 2'd0;  // [8] enable, [7:0] period
   localparam logic [1:0] REG_PHASE0 = 2'd1;  // [15:8] fall, [7:0] rise
   localparam logic [1:0] REG_PHASE1 = 2'd2;
   localparam logic [1:0] REG_STATUS = 2'd3;  // read only, [0] stable

   //####################
   // structs
   //####################
   typedef struct packed {
      logic       enable;
      div_count_t period;  // 0 is bypass
      div_count_t rise0;
      div_count_t fall0;
      div_count_t rise1;
      div_count_t fall1;
   } div_cfg_t;

   typedef struct packed {
      logic rise0;
      logic fall0;
      logic rise1;
      logic fall1;
      logic stable;
   } div_stat_t;

   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat;
   } wb_req_t;

   typedef struct packed {
      logic     ack;
      wb_data_t dat;
   } wb_rsp_t;

   // divide by 2, 50% duty, disabled
   localparam div_cfg_t CFG_RST = '{
      enable: 1'b0,
      period: 8'd1,
      rise0:  8'd0,
      fall0:  8'd1,
      rise1:  8'd0,
      fall1:  8'd1
   };

endpackage

// File: source/clk_divider.sv
`timescale 1ns/1ps
//####################
// clock divider channel
// 8-bit period counter, two output clocks with
// programmable edges, match flags, stable detect
//####################
module clk_divider (
   input  logic                  clk,
   input  logic                  nreset,     // async, active low
   input  logic                  clkchange,  // config was just written
   input  clkctl_pkg::div_cfg_t  cfg,
   output logic                  clkout0,
   output logic                  clkout1,
   output clkctl_pkg::div_stat_t stat
);
   import clkctl_pkg::*;

   div_count_t counter;
   logic       period_match;
   logic       tick;          // end of a period, channel running
   logic [2:0] match_cnt;     // periods seen since last change
   logic       stable_q;
   logic       clkout0_q;
   logic       clkout1_q;
   logic       clkout1_neg;   // half cycle late copy of clkout1_q
   logic       bypass;
   logic       div2;

   //####################
   // cycle counter
   //####################
   assign period_match = (counter == cfg.period);
   assign tick         = period_match & cfg.enable;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         counter <= '0;
      end else if (cfg.enable) begin  // holds while disabled
         if (period_match)
            counter <= '0;
         else
            counter <= counter + 8'd1;  // wraps past 255 if period lowered
      end
   end

   //####################
   // change detect
   //####################
   // count 7 matches, eighth match sets stable
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         match_cnt <= '0;
         stable_q  <= 1'b0;
      end else if (clkchange) begin   // restart on every config write
         match_cnt <= '0;
         stable_q  <= 1'b0;
      end else if (tick) begin
         if (match_cnt == 3'd7)
            stable_q <= 1'b1;
         else
            match_cnt <= match_cnt + 3'd1;
      end
   end

   // edge selectors, plain compares
   assign stat = '{
      rise0:  (counter == cfg.rise0),
      fall0:  (counter == cfg.fall0),
      rise1:  (counter == cfg.rise1),
      fall1:  (counter == cfg.fall1),
      stable: stable_q
   };

   //####################
   // output clocks
   //####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         clkout0_q <= 1'b0;
         clkout1_q <= 1'b0;
      end else begin
         if (stat.rise0)
            clkout0_q <= 1'b1;
         else if (stat.fall0)
            clkout0_q <= 1'b0;   // rise wins on equal positions
         if (stat.rise1)
            clkout1_q <= 1'b1;
         else if (stat.fall1)
            clkout1_q <= 1'b0;
      end
   end

   // shifted copy for divide by 2
   always_ff @(negedge clk or negedge nreset) begin
      if (!nreset)
         clkout1_neg <= 1'b0;
      else
         clkout1_neg <= clkout1_q;
   end

   assign bypass = (cfg.period == 8'd0);
   assign div2   = (cfg.period == 8'd1);

   assign clkout0 = bypass ? clk : clkout0_q;
   assign clkout1 = bypass ? clk :
                    div2   ? clkout1_neg :  // quadrature at div 2
                             clkout1_q;

endmodule

// File: source/clk_cfg_regs.sv
`timescale 1ns/1ps
//####################
// clock control registers
// Wishbone classic slave, per-channel config,
// status read-back and clkchange pulses
//####################
module clk_cfg_regs #(
   parameter int NUM_DIV = 2   // channels, 1 to 8
) (
   input  logic                  clk,
   input  logic                  nreset,
   input  clkctl_pkg::wb_req_t   wb_req,
   output clkctl_pkg::wb_rsp_t   wb_rsp,
   output clkctl_pkg::div_cfg_t  cfg [NUM_DIV],
   output logic [NUM_DIV-1:0]    clkchange,
   input  clkctl_pkg::div_stat_t stat [NUM_DIV]
);
   import clkctl_pkg::*;

   logic       req;        // new request this cycle
   logic       wr;
   logic       rd;
   logic [5:0] chan_sel;   // channel window from adr[7:2]
   logic [1:0] reg_sel;    // word inside window
   logic       ack_q;
   wb_data_t   rd_word;
   wb_data_t   rd_q;

   //####################
   // decode
   //####################
   // ~ack_q keeps ack to a single cycle while host drops stb
   assign req      = wb_req.cyc & wb_req.stb & ~ack_q;
   assign wr       = req & wb_req.we;
   assign rd       = req & ~wb_req.we;
   assign chan_sel = wb_req.adr[7:2];
   assign reg_sel  = wb_req.adr[1:0];

   //####################
   // config registers
   //####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ack_q     <= 1'b0;
         clkchange <= '0;
         for (int i = 0; i < NUM_DIV; i++)
            cfg[i] <= CFG_RST;
      end else begin
         ack_q     <= req;
         clkchange <= '0;   // one cycle pulse
         if (wr) begin
            for (int i = 0; i < NUM_DIV; i++) begin
               if (chan_sel == i) begin   // unmapped channels fall through
                  case (reg_sel)
                     REG_CTRL: begin
                        cfg[i].period <= wb_req.dat[7:0];
                        cfg[i].enable <= wb_req.dat[8];
                        clkchange[i]  <= 1'b1;
                     end
                     REG_PHASE0: begin
                        cfg[i].rise0 <= wb_req.dat[7:0];
                        cfg[i].fall0 <= wb_req.dat[15:8];
                        clkchange[i] <= 1'b1;
                     end
                     REG_PHASE1: begin
                        cfg[i].rise1 <= wb_req.dat[7:0];
                        cfg[i].fall1 <= wb_req.dat[15:8];
                        clkchange[i] <= 1'b1;
                     end
                     default: ;   // status is read only
                  endcase
               end
            end
         end
      end
   end

   //####################
   // read mux
   //####################
   always_comb begin
      rd_word = '0;   // unmapped reads return zero
      for (int i = 0; i < NUM_DIV; i++) begin
         if (chan_sel == i) begin
            case (reg_sel)
               REG_CTRL:   rd_word = {23'd0, cfg[i].enable, cfg[i].period};
               REG_PHASE0: rd_word = {16'd0, cfg[i].fall0, cfg[i].rise0};
               REG_PHASE1: rd_word = {16'd0, cfg[i].fall1, cfg[i].rise1};
               default:    rd_word = {31'd0, stat[i].stable};
            endcase
         end
      end
   end

   // read data held for the ack cycle
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         rd_q <= '0;
      else if (rd)
         rd_q <= rd_word;   // status sampled at the request edge
   end

   assign wb_rsp = '{ack: ack_q, dat: rd_q};

endmodule

// File: source/clkctl_top.sv
`timescale 1ns/1ps
//####################
// clock control top
// register block driving NUM_DIV divider channels
//####################
module clkctl_top #(
   parameter int NUM_DIV = 2   // channels, 1 to 8
) (
   input  logic                  clk,
   input  logic                  nreset,
   input  clkctl_pkg::wb_req_t   wb_req,
   output clkctl_pkg::wb_rsp_t   wb_rsp,
   output logic [NUM_DIV-1:0]    clkout0,
   output logic [NUM_DIV-1:0]    clkout1,
   output clkctl_pkg::div_stat_t stat [NUM_DIV]
);
   import clkctl_pkg::*;

   div_cfg_t           cfg [NUM_DIV];   // per channel config
   logic [NUM_DIV-1:0] clkchange;

   //####################
   // register block
   //####################
   clk_cfg_regs #(
      .NUM_DIV (NUM_DIV)
   ) u_regs (
      .clk       (clk),
      .nreset    (nreset),
      .wb_req    (wb_req),
      .wb_rsp    (wb_rsp),
      .cfg       (cfg),
      .clkchange (clkchange),
      .stat      (stat)        // flags back for status reads
   );

   //####################
   // divider channels
   //####################
   for (genvar i = 0; i < NUM_DIV; i++) begin : g_div
      clk_divider u_div (
         .clk       (clk),
         .nreset    (nreset),
         .clkchange (clkchange[i]),
         .cfg       (cfg[i]),
         .clkout0   (clkout0[i]),
         .clkout1   (clkout1[i]),
         .stat      (stat[i])
      );
   end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps
//####################
// testbench clock and reset
// 40 ns clock, reset low for the first 8 cycles
//####################
module tb_clock #(
   parameter int HALF_NS    = 20,  // half period
   parameter int RST_CYCLES = 8
) (
   output logic clk,
   output logic nreset
);

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

   initial begin
      nreset = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1 nreset = 1'b1;  // release just after an edge
   end

endmodule

// File: tests/clkctl_sva.sv
`timescale 1ns/1ps
//####################
// bound assertions
// Wishbone ack handshake and divider stable flag
//####################
module clkctl_sva (
   input logic clk,
   input logic nreset,
   input logic ack,
   input logic cyc,
   input logic stb,
   input logic clkchange,
   input logic stable
);

   // ack is a single cycle pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (!nreset) ack |=> !ack)
      else $error("ack high for two cycles in a row");

   // ack answers a request seen on the edge before
   ack_after_req: assert property (@(posedge clk) disable iff (!nreset)
      ack |-> $past(cyc && stb))
      else $error("ack without a cyc and stb request");

   // a config write restarts the stable count
   stable_cleared: assert property (@(posedge clk) disable iff (!nreset)
      clkchange |=> !stable)
      else $error("stable still high after clkchange");

endmodule

// register block, divider inputs tied low
bind clk_cfg_regs clkctl_sva u_sva (
   .clk       (clk),
   .nreset    (nreset),
   .ack       (wb_rsp.ack),
   .cyc       (wb_req.cyc),
   .stb       (wb_req.stb),
   .clkchange (1'b0),
   .stable    (1'b0)
);

// every divider channel, bus inputs tied low
bind clk_divider clkctl_sva u_sva (
   .clk       (clk),
   .nreset    (nreset),
   .ack       (1'b0),
   .cyc       (1'b0),
   .stb       (1'b0),
   .clkchange (clkchange),
   .stable    (stat.stable)
);

// File: tests/clkctl_tb.sv
`timescale 1ns/1ps
//####################
// clock control testbench
// programs the divider channels from a table over Wishbone
// and checks read-back, stable flag, edges, duty and bypass
//####################
module clkctl_tb;
   import clkctl_pkg::*;

   localparam int NUM_DIV   = 2;
   localparam int ROWS      = 5;
   localparam int WD_CYCLES = ROWS * 8 * 257 + 2000;  // stable waits plus margin

   logic               clk;
   logic               nreset;
   wb_req_t            wb_req;
   wb_rsp_t            wb_rsp;
   logic [NUM_DIV-1:0] clkout0;
   logic [NUM_DIV-1:0] clkout1;
   div_stat_t          stat [NUM_DIV];

   integer seed   = 90;
   int     cycles = 0;  // rising edges so far
   int     checks = 0;
   int     errors = 0;

   //####################
   // stimulus table
   //####################
   // row 1 is bypass and row 4 disables
   // junk in unused upper bits
   int       tab_chan [ROWS] = '{0, 1, 1, 0, 1};
   wb_data_t tab_ctrl [ROWS] = '{32'hDEAD_0109, 32'h1234_0100, 32'hFFFF_FF04,
                                 32'h8000_010F, 32'hFFFF_FE04};
   wb_data_t exp_ctrl [ROWS] = '{32'h109, 32'h100, 32'h104, 32'h10F, 32'h004};
   wb_data_t tab_ph0  [ROWS];  // phases drawn at start
   wb_data_t tab_ph1  [ROWS];
   wb_data_t exp_ph0  [ROWS];
   wb_data_t exp_ph1  [ROWS];

   // last setup per channel
   int run_en [NUM_DIV] = '{default: 0};
   int run_p  [NUM_DIV];
   int run_r  [NUM_DIV];
   int run_f  [NUM_DIV];

   tb_clock u_clk (.clk (clk), .nreset (nreset));

   clkctl_top #(.NUM_DIV (NUM_DIV)) uut (
      .clk     (clk),
      .nreset  (nreset),
      .wb_req  (wb_req),
      .wb_rsp  (wb_rsp),
      .clkout0 (clkout0),
      .clkout1 (clkout1),
      .stat    (stat)
   );

   always @(posedge clk)
      cycles <= cycles + 1;

   //####################
   // helpers
   //####################
   function automatic int pick(input int max);  // 0 to max
      return $unsigned($random(seed)) % (max + 1);
   endfunction

   function automatic wb_addr_t reg_addr(input int ch, input logic [1:0] r);
      return wb_addr_t'(ch * 4 + r);  // 4 words per channel
   endfunction

   task automatic compare(input string name, input wb_data_t want, input wb_data_t got);
      checks++;
      if (got !== want) begin
         errors++;
         $display("Fail %0t %s expected %h actual %h", $time, name, want, got);
      end
   endtask

   // one classic cycle with the request 1 ns after the edge
   task automatic access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                         output wb_data_t rdat);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      do begin
         @(posedge clk);
         #1;
         n++;
      end while (!wb_rsp.ack && n < 16);
      if (!wb_rsp.ack) begin
         errors++;
         $display("no ack from the slave for address %h", adr);
      end
      rdat   = wb_rsp.dat;
      wb_req = '0;  // stb drops on ack
   endtask

   task automatic write_reg(input wb_addr_t adr, input wb_data_t wdat);
      wb_data_t unused;
      access(1'b1, adr, wdat, unused);
   endtask

   task automatic read_reg(input wb_addr_t adr, output wb_data_t rdat);
      access(1'b0, adr, '0, rdat);
   endtask

   // STATUS polled until stable within the bound from t0
   task automatic poll_stable(input int ch, input int p, input int t0);
      wb_data_t rd;
      int       bound;
      bound = 8 * (p + 1) + 4;
      rd    = '0;
      while (rd[0] !== 1'b1 && cycles - t0 <= bound)
         read_reg(reg_addr(ch, REG_STATUS), rd);
      if (rd[0] !== 1'b1 || cycles - t0 > bound) begin
         errors++;
         $display("channel %0d stable flag not set within %0d cycles", ch, bound);
      end
   endtask

   // rise0 to rise0 and rise0 to fall0 distances sampled mid cycle
   task automatic measure_edges(input int ch, input int p, input int r, input int f);
      int n;
      int lim;
      int t_r1;
      int t_r2;
      int t_f;
      n    = 0;
      lim  = 3 * (p + 1) + 4;
      t_r1 = -1;
      t_r2 = -1;
      t_f  = -1;
      while (t_r2 < 0 && n < lim) begin
         @(negedge clk);
         n++;
         if (stat[ch].rise0) begin
            if (t_r1 < 0)
               t_r1 = n;
            else
               t_r2 = n;
         end
         if (t_r1 >= 0 && t_f < 0 && stat[ch].fall0)
            t_f = n;  // same cycle as rise0 when equal
      end
      if (t_r2 < 0) begin
         errors++;
         $display("channel %0d rise0 did not pulse twice in %0d cycles", ch, lim);
      end else begin
         compare($sformatf("ch%0d rise0 spacing", ch), p + 1, t_r2 - t_r1);
         compare($sformatf("ch%0d rise0 to fall0", ch), (f - r + p + 1) % (p + 1),
                 t_f - t_r1);
      end
   endtask

   // high cycles of clkout0 over one period
   task automatic measure_duty(input int ch, input int p, input int r, input int f);
      int high;
      high = 0;
      for (int k = 0; k <= p; k++) begin
         @(negedge clk);
         if (clkout0[ch])
            high++;
      end
      compare($sformatf("ch%0d clkout0 high cycles", ch), f - r, high);
   endtask

   task automatic hold_flags(input int ch);  // counter frozen while disabled
      div_stat_t ref_stat;
      repeat (2) @(posedge clk);
      @(negedge clk);
      ref_stat = stat[ch];
      for (int k = 0; k < 20; k++) begin
         @(negedge clk);
         compare($sformatf("ch%0d stat held", ch), {27'd0, ref_stat}, {27'd0, stat[ch]});
      end
   endtask

   task automatic bypass_levels(input int ch);  // outputs follow clk
      for (int k = 0; k < 4; k++) begin
         @(posedge clk);
         #10;
         compare($sformatf("ch%0d clkout1,clkout0 clk high", ch), 32'd3,
                 {30'd0, clkout1[ch], clkout0[ch]});
         @(negedge clk);
         #10;
         compare($sformatf("ch%0d clkout1,clkout0 clk low", ch), 32'd0,
                 {30'd0, clkout1[ch], clkout0[ch]});
      end
   endtask

   //####################
   // main sequence
   //####################
   initial begin
      wb_data_t rd;
      int       ch;
      int       p;
      int       en;
      int       r;
      int       f;
      int       t0;
      wb_req = '0;
      // phase0 rise below fall and phase1 anywhere up to the period
      for (int i = 0; i < ROWS; i++) begin
         p          = exp_ctrl[i][7:0];
         r          = (p == 0) ? 0 : pick(p - 1);
         f          = (p == 0) ? 0 : r + 1 + pick(p - 1 - r);
         exp_ph0[i] = {16'd0, 8'(f), 8'(r)};
         tab_ph0[i] = {16'($random(seed)), exp_ph0[i][15:0]};
         exp_ph1[i] = {16'd0, 8'(pick(p)), 8'(pick(p))};
         tab_ph1[i] = {16'($random(seed)), exp_ph1[i][15:0]};
      end

      repeat (2) @(negedge clk);  // still in reset
      compare("clkout0 in reset", 32'd0, 32'(clkout0));
      compare("clkout1 in reset", 32'd0, 32'(clkout1));
      compare("wb_rsp.ack in reset", 32'd0, {31'd0, wb_rsp.ack});
      @(posedge nreset);

      for (int c = 0; c < NUM_DIV; c++) begin  // reset values
         read_reg(reg_addr(c, REG_CTRL), rd);
         compare($sformatf("ch%0d CTRL reset", c), 32'h001, rd);
         read_reg(reg_addr(c, REG_PHASE0), rd);
         compare($sformatf("ch%0d PHASE0 reset", c), 32'h100, rd);
         read_reg(reg_addr(c, REG_PHASE1), rd);
         compare($sformatf("ch%0d PHASE1 reset", c), 32'h100, rd);
         read_reg(reg_addr(c, REG_STATUS), rd);
         compare($sformatf("ch%0d STATUS reset", c), 32'h0, rd);
      end
      write_reg(reg_addr(0, REG_STATUS), 32'hFFFF_FFFF);  // read only
      read_reg(reg_addr(0, REG_STATUS), rd);
      compare("ch0 STATUS after write", 32'h0, rd);
      read_reg(reg_addr(0, REG_CTRL), rd);
      compare("ch0 CTRL after STATUS write", 32'h001, rd);
      write_reg(reg_addr(NUM_DIV, REG_CTRL), 32'h0000_01FF);  // first unmapped window
      read_reg(reg_addr(NUM_DIV, REG_CTRL), rd);
      compare("unmapped CTRL", 32'h0, rd);
      read_reg(8'hFF, rd);
      compare("unmapped last word", 32'h0, rd);

      for (int i = 0; i < ROWS; i++) begin
         ch = tab_chan[i];
         p  = exp_ctrl[i][7:0];
         en = exp_ctrl[i][8];
         r  = exp_ph0[i][7:0];
         f  = exp_ph0[i][15:8];
         write_reg(reg_addr(ch, REG_PHASE0), tab_ph0[i]);
         write_reg(reg_addr(ch, REG_PHASE1), tab_ph1[i]);
         write_reg(reg_addr(ch, REG_CTRL), tab_ctrl[i]);
         t0 = cycles;  // ack edge of the CTRL write
         read_reg(reg_addr(ch, REG_STATUS), rd);
         compare($sformatf("ch%0d STATUS after config", ch), 32'h0, rd);
         read_reg(reg_addr(ch, REG_CTRL), rd);
         compare($sformatf("ch%0d CTRL", ch), exp_ctrl[i], rd);
         read_reg(reg_addr(ch, REG_PHASE0), rd);
         compare($sformatf("ch%0d PHASE0", ch), exp_ph0[i], rd);
         read_reg(reg_addr(ch, REG_PHASE1), rd);
         compare($sformatf("ch%0d PHASE1", ch), exp_ph1[i], rd);
         if (en) begin
            poll_stable(ch, p, t0);
            measure_edges(ch, p, r, f);
            if (f > r)
               measure_duty(ch, p, r, f);
         end else begin
            hold_flags(ch);
         end
         if (p == 0)
            bypass_levels(ch);
         run_en[ch] = en;
         run_p[ch]  = p;
         run_r[ch]  = r;
         run_f[ch]  = f;
         // the other running channels keep their rhythm
         for (int oc = 0; oc < NUM_DIV; oc++) begin
            if (oc != ch && run_en[oc]) begin
               @(negedge clk);
               compare($sformatf("ch%0d stable", oc), 32'd1, {31'd0, stat[oc].stable});
               measure_edges(oc, run_p[oc], run_r[oc], run_f[oc]);
            end
         end
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // watchdog
   initial begin
      #(WD_CYCLES * 40);
      $display("watchdog timeout after %0d cycles, tests did not finish", WD_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: all.f
source/clkctl_pkg.sv
source/clk_divider.sv
source/clk_cfg_regs.sv
source/clkctl_top.sv
tests/tb_clock.sv
tests/clkctl_sva.sv
tests/clkctl_tb.sv

// File: Makefile
# Verilator build and run for the clock control block
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= clkctl_tb
FLIST     ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

SIM_BIN := $(BUILD)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

# the run passes only if the log holds the pass line
run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
